/* tb.f */
+incdir+common
common/perf_pkg.sv
common/perf_probe_if.sv
src/probe_sampler.sv
counters/perf_counter_bank.sv
src/stats_readout.sv
src/tile_perf_monitor.sv
sim/tb_tile_perf_monitor.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator
# a $fatal in the testbench gives a non-zero exit status

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_tile_perf_monitor \
  --Mdir obj_dir \
  -f tb.f \
  && ./obj_dir/Vtb_tile_perf_monitor \
  || { echo "simulation did not complete cleanly"; exit 1; }

/* sim/tb_tile_perf_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

`include "perf_defs.svh"

module tb_tile_perf_monitor import perf_pkg::*;
();

  localparam int clk_period_lp     = 40;
  localparam int reset_cycles_lp   = 4;
  localparam int settle_cycles_lp  = 3;
  localparam int sel_codes_lp      = 1 << `PERF_SEL_W;
  localparam int read_cycles_lp    = sel_codes_lp * 3;
  localparam int run_cycles_lp     = 300;
  localparam int restart_cycles_lp = 40;
  localparam int read_phases_lp    = 4;
  localparam int credit_max_lp     = (1 << `PERF_CREDIT_W) - 1;
  localparam int restart_floor_lp  = 20;
  localparam int total_cycles_lp   = reset_cycles_lp + 2 * run_cycles_lp + restart_cycles_lp
                                     + read_phases_lp * (settle_cycles_lp + read_cycles_lp) + 4;

  // one cycle of probe inputs
  typedef struct packed {
    logic                      freeze;
    logic                      imem_wait;
    logic                      dmem_wait;
    logic                      dmem_en;
    logic                      rsrv_stall;
    logic                      dx_stall;
    logic                      redirect;
    logic                      instr;
    logic                      cgni_ready;
    logic                      cgno_ready;
    logic                      credit_ready;
    logic [`PERF_CREDIT_W-1:0] credits;
  } probe_drive_s;

  logic                      clk_i = 1'b0;
  logic                      rst_n_i;
  logic                      freeze_i;
  logic                      imem_wait_i;
  logic                      dmem_wait_i;
  logic                      dmem_en_i;
  logic                      rsrv_stall_i;
  logic                      dx_stall_i;
  logic                      redirect_i;
  logic                      instr_retired_i;
  logic                      cgni_ready_i;
  logic                      cgno_ready_i;
  logic                      credit_ready_i;
  logic [`PERF_CREDIT_W-1:0] store_credits_i;
  logic                      rd_en_i;
  logic [`PERF_SEL_W-1:0]    rd_sel_i;
  logic                      rd_valid_o;
  logic [`PERF_CYC_W-1:0]    rd_data_o;

  perf_stats_s            model_stats;
  logic                   model_prev_freeze;
  logic                   expect_valid;
  stat_sel_e              sel_q[$];
  logic [`PERF_CYC_W-1:0] data_q[$];

  tile_perf_monitor tile_perf_monitor_i
  (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .freeze_i        (freeze_i),
    .imem_wait_i     (imem_wait_i),
    .dmem_wait_i     (dmem_wait_i),
    .dmem_en_i       (dmem_en_i),
    .rsrv_stall_i    (rsrv_stall_i),
    .dx_stall_i      (dx_stall_i),
    .redirect_i      (redirect_i),
    .instr_retired_i (instr_retired_i),
    .cgni_ready_i    (cgni_ready_i),
    .cgno_ready_i    (cgno_ready_i),
    .credit_ready_i  (credit_ready_i),
    .store_credits_i (store_credits_i),
    .rd_en_i         (rd_en_i),
    .rd_sel_i        (rd_sel_i),
    .rd_valid_o      (rd_valid_o),
    .rd_data_o       (rd_data_o)
  );

  always #(clk_period_lp / 2) clk_i = ~clk_i;

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1, "run stopped");
  endtask

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("[FAIL] rd_valid_o got %h expected %h", got, exp));
  endtask

  task automatic check_stat(input stat_sel_e sel, input logic [`PERF_CYC_W-1:0] got,
                            input logic [`PERF_CYC_W-1:0] exp);
    if (got !== exp)
      fail_run($sformatf("[FAIL] rd_data_o sel %h got %h expected %h", sel, got, exp));
  endtask

  // stats after one driven input cycle
  function automatic perf_stats_s model_step(input perf_stats_s s, input logic prev_frozen,
                                             input probe_drive_s d);
    perf_stats_s n;
    n = s;
    if (prev_frozen && !d.freeze)
    begin
      n            = '0; // clear cycle, not counted
      n.min_credit = '1;
    end
    else if (!prev_frozen && !d.freeze)
    begin
      n.cycles = s.cycles + 1'b1;
      if (d.instr)
        n.instrs = s.instrs + 1'b1;
      if (d.dmem_wait && d.dmem_en)
        n.dmem = s.dmem + 1'b1;
      else if (d.rsrv_stall)
        n.rsrv = s.rsrv + 1'b1;
      else if (d.dx_stall)
        n.dx = s.dx + 1'b1;
      else if (d.redirect)
        n.bt = s.bt + 1'b1;
      if (d.imem_wait)
        n.imem = s.imem + 1'b1;
      if (!d.cgni_ready)
        n.cgni_full = s.cgni_full + 1'b1;
      if (!d.cgno_ready)
        n.cgno_full = s.cgno_full + 1'b1;
      if (!d.credit_ready)
        n.credit_full = s.credit_full + 1'b1;
      if (d.credits < s.min_credit)
        n.min_credit = d.credits;
    end
    return n;
  endfunction

  function automatic logic [`PERF_CYC_W-1:0] expected_read(input perf_stats_s s,
                                                           input stat_sel_e sel);
    logic [`PERF_CYC_W-1:0] v;
    v = '0;
    case (sel)
      STAT_CYCLES:     v = s.cycles;
      STAT_INSTRS:     v = s.instrs;
      STAT_DMEM:       v[`PERF_CNT_W-1:0] = s.dmem;
      STAT_IMEM:       v[`PERF_CNT_W-1:0] = s.imem;
      STAT_DX:         v[`PERF_CNT_W-1:0] = s.dx;
      STAT_BT:         v[`PERF_CNT_W-1:0] = s.bt;
      STAT_RSRV:       v[`PERF_CNT_W-1:0] = s.rsrv;
      STAT_CGNI:       v[`PERF_CNT_W-1:0] = s.cgni_full;
      STAT_CGNO:       v[`PERF_CNT_W-1:0] = s.cgno_full;
      STAT_CREDIT:     v[`PERF_CNT_W-1:0] = s.credit_full;
      STAT_MIN_CREDIT: v[`PERF_CREDIT_W-1:0] = s.min_credit;
      default:         v = '0;
    endcase
    return v;
  endfunction

  function automatic probe_drive_s random_drive(input logic frozen, input int credit_floor);
    probe_drive_s d;
    logic [31:0]  rnd;
    logic [31:0]  cred;
    rnd            = $urandom();
    cred           = $urandom_range(credit_max_lp, credit_floor);
    d.freeze       = frozen;
    d.imem_wait    = &rnd[1:0];
    d.dmem_wait    = rnd[2];
    d.dmem_en      = rnd[3]; // dmem stall about one in four
    d.rsrv_stall   = &rnd[5:4];
    d.dx_stall     = &rnd[7:6];
    d.redirect     = &rnd[9:8];
    d.instr        = rnd[10];
    d.cgni_ready   = |rnd[12:11];
    d.cgno_ready   = |rnd[14:13];
    d.credit_ready = |rnd[16:15];
    d.credits      = cred[`PERF_CREDIT_W-1:0];
    return d;
  endfunction

  task automatic drive_cycle(input probe_drive_s d);
    @(posedge clk_i);
    freeze_i          <= d.freeze;
    imem_wait_i       <= d.imem_wait;
    dmem_wait_i       <= d.dmem_wait;
    dmem_en_i         <= d.dmem_en;
    rsrv_stall_i      <= d.rsrv_stall;
    dx_stall_i        <= d.dx_stall;
    redirect_i        <= d.redirect;
    instr_retired_i   <= d.instr;
    cgni_ready_i      <= d.cgni_ready;
    cgno_ready_i      <= d.cgno_ready;
    credit_ready_i    <= d.credit_ready;
    store_credits_i   <= d.credits;
    model_stats       = model_step(model_stats, model_prev_freeze, d);
    model_prev_freeze = d.freeze;
  endtask

  task automatic settle_frozen();
    repeat (settle_cycles_lp) drive_cycle(random_drive(1'b1, 0));
  endtask

  task automatic run_unfrozen(input int cycles, input int credit_floor);
    repeat (cycles) drive_cycle(random_drive(1'b0, credit_floor));
  endtask

  task automatic run_with_freeze_spans(input int cycles);
    int   span_left;
    logic frozen;
    span_left = 0;
    frozen    = 1'b0;
    for (int i = 0; i < cycles; i++)
    begin
      if (span_left == 0)
      begin
        frozen    = ~frozen;
        span_left = frozen ? $urandom_range(8, 1) : $urandom_range(30, 5);
      end
      drive_cycle(random_drive(frozen, 0));
      span_left--;
    end
  endtask

  // request, one cycle with valid, one idle cycle
  task automatic issue_read(input stat_sel_e sel);
    @(posedge clk_i);
    rd_en_i  <= 1'b1;
    rd_sel_i <= sel;
    sel_q.push_back(sel);
    data_q.push_back(expected_read(model_stats, sel));
    @(posedge clk_i);
    rd_en_i <= 1'b0;
    @(posedge clk_i);
  endtask

  task automatic read_all_stats();
    for (int code = 0; code < sel_codes_lp; code++)
      issue_read(stat_sel_e'(code[`PERF_SEL_W-1:0]));
  endtask

  always @(posedge clk_i)
  begin
    if (!rst_n_i)
      expect_valid <= 1'b0;
    else
      expect_valid <= rd_en_i;
  end

  // outputs settle well before the falling edge
  always @(negedge clk_i)
  begin
    if (rst_n_i === 1'b1)
    begin
      check_valid(rd_valid_o, expect_valid);
      if (expect_valid)
        check_stat(sel_q.pop_front(), rd_data_o, data_q.pop_front());
    end
  end

  initial
  begin
    #(total_cycles_lp * clk_period_lp * 2);
    fail_run("timeout: the run did not finish in the expected number of cycles");
  end

  initial
  begin
    void'($urandom(32'h2a72));
    rst_n_i           = 1'b0;
    freeze_i          = 1'b1;
    imem_wait_i       = 1'b0;
    dmem_wait_i       = 1'b0;
    dmem_en_i         = 1'b0;
    rsrv_stall_i      = 1'b0;
    dx_stall_i        = 1'b0;
    redirect_i        = 1'b0;
    instr_retired_i   = 1'b0;
    cgni_ready_i      = 1'b1;
    cgno_ready_i      = 1'b1;
    credit_ready_i    = 1'b1;
    store_credits_i   = '0;
    rd_en_i           = 1'b0;
    rd_sel_i          = '0;
    model_stats            = '0;
    model_stats.min_credit = '1;
    model_prev_freeze      = 1'b1;
    repeat (reset_cycles_lp) @(posedge clk_i);
    rst_n_i <= 1'b1;

    settle_frozen(); // reset values, freeze still high
    read_all_stats();

    run_unfrozen(run_cycles_lp, 0);
    settle_frozen();
    read_all_stats();

    run_with_freeze_spans(run_cycles_lp);
    settle_frozen();
    read_all_stats();

    // unfreeze clears, then only high credit values
    run_unfrozen(restart_cycles_lp, restart_floor_lp);
    settle_frozen();
    read_all_stats();

    repeat (2) @(posedge clk_i);
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

/* src/tile_perf_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

`include "perf_defs.svh"

module tile_perf_monitor import perf_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      freeze_i,
  input  logic                      imem_wait_i,
  input  logic                      dmem_wait_i,
  input  logic                      dmem_en_i,
  input  logic                      rsrv_stall_i,
  input  logic                      dx_stall_i,
  input  logic                      redirect_i,
  input  logic                      instr_retired_i,
  input  logic                      cgni_ready_i,
  input  logic                      cgno_ready_i,
  input  logic                      credit_ready_i,
  input  logic [`PERF_CREDIT_W-1:0] store_credits_i,
  input  logic                      rd_en_i,
  input  logic [`PERF_SEL_W-1:0]    rd_sel_i,
  output logic                      rd_valid_o,
  output logic [`PERF_CYC_W-1:0]    rd_data_o
);

  perf_stats_s stats;

  perf_probe_if probe_if ();

  probe_sampler probe_sampler_i
  (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .freeze_i        (freeze_i),
    .imem_wait_i     (imem_wait_i),
    .dmem_wait_i     (dmem_wait_i),
    .dmem_en_i       (dmem_en_i),
    .rsrv_stall_i    (rsrv_stall_i),
    .dx_stall_i      (dx_stall_i),
    .redirect_i      (redirect_i),
    .instr_retired_i (instr_retired_i),
    .cgni_ready_i    (cgni_ready_i),
    .cgno_ready_i    (cgno_ready_i),
    .credit_ready_i  (credit_ready_i),
    .store_credits_i (store_credits_i),
    .probe           (probe_if.sampler)
  );

  perf_counter_bank perf_counter_bank_i
  (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .probe   (probe_if.bank),
    .stats_o (stats)
  );

  stats_readout stats_readout_i
  (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .stats_i    (stats),
    .rd_en_i    (rd_en_i),
    .rd_sel_i   (stat_sel_e'(rd_sel_i)), // raw code, invalid values allowed
    .rd_valid_o (rd_valid_o),
    .rd_data_o  (rd_data_o)
  );

endmodule

`default_nettype wire

/* src/stats_readout.sv */
`timescale 1ns/100ps
`default_nettype none

`include "perf_defs.svh"

module stats_readout import perf_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  perf_stats_s            stats_i,
  input  logic                   rd_en_i,
  input  stat_sel_e              rd_sel_i,
  output logic                   rd_valid_o,
  output logic [`PERF_CYC_W-1:0] rd_data_o
);

  localparam int cnt_pad_lp    = `PERF_CYC_W - `PERF_CNT_W;
  localparam int credit_pad_lp = `PERF_CYC_W - `PERF_CREDIT_W;

  logic [`PERF_CYC_W-1:0] sel_data;

  always_comb
  begin
    case (rd_sel_i)
      STAT_CYCLES:     sel_data = stats_i.cycles;
      STAT_INSTRS:     sel_data = stats_i.instrs;
      STAT_DMEM:       sel_data = {{cnt_pad_lp{1'b0}}, stats_i.dmem};
      STAT_IMEM:       sel_data = {{cnt_pad_lp{1'b0}}, stats_i.imem};
      STAT_DX:         sel_data = {{cnt_pad_lp{1'b0}}, stats_i.dx};
      STAT_BT:         sel_data = {{cnt_pad_lp{1'b0}}, stats_i.bt};
      STAT_RSRV:       sel_data = {{cnt_pad_lp{1'b0}}, stats_i.rsrv};
      STAT_CGNI:       sel_data = {{cnt_pad_lp{1'b0}}, stats_i.cgni_full};
      STAT_CGNO:       sel_data = {{cnt_pad_lp{1'b0}}, stats_i.cgno_full};
      STAT_CREDIT:     sel_data = {{cnt_pad_lp{1'b0}}, stats_i.credit_full};
      STAT_MIN_CREDIT: sel_data = {{credit_pad_lp{1'b0}}, stats_i.min_credit};
      default:         sel_data = '0; // unused codes
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      rd_valid_o <= 1'b0;
    else
      rd_valid_o <= rd_en_i; // single cycle per request
  end

  always_ff @(posedge clk_i)
  begin
    if (rd_en_i)
      rd_data_o <= sel_data;
  end

  a_sel_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rd_en_i |-> !$isunknown(rd_sel_i))
  else
    $error("read selector has unknown bits");

endmodule

`default_nettype wire

/* counters/perf_counter_bank.sv */
`timescale 1ns/100ps
`default_nettype none

`include "perf_defs.svh"

module perf_counter_bank import perf_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  perf_probe_if.bank probe,
  output perf_stats_s stats_o
);

  localparam perf_stats_s stats_clear_lp = '{
    cycles:      '0,
    instrs:      '0,
    dmem:        '0,
    imem:        '0,
    dx:          '0,
    bt:          '0,
    rsrv:        '0,
    cgni_full:   '0,
    cgno_full:   '0,
    credit_full: '0,
    min_credit:  '1
  };

  perf_stats_s stats_r;
  perf_stats_s stats_n;

  always_comb
  begin
    stats_n = stats_r;
    if (probe.clear)
    begin
      stats_n = stats_clear_lp;
    end
    else if (probe.run)
    begin
      stats_n.cycles = stats_r.cycles + 1'b1;

      if (probe.ev.instr)
        stats_n.instrs = stats_r.instrs + 1'b1;

      // memory stall classes, one at most
      if (probe.ev.dmem)
        stats_n.dmem = stats_r.dmem + 1'b1;
      if (probe.ev.rsrv)
        stats_n.rsrv = stats_r.rsrv + 1'b1;
      if (probe.ev.dx)
        stats_n.dx = stats_r.dx + 1'b1;
      if (probe.ev.bt)
        stats_n.bt = stats_r.bt + 1'b1;

      if (probe.ev.imem)
        stats_n.imem = stats_r.imem + 1'b1;

      // buffer full cycles
      if (probe.ev.cgni_full)
        stats_n.cgni_full = stats_r.cgni_full + 1'b1;
      if (probe.ev.cgno_full)
        stats_n.cgno_full = stats_r.cgno_full + 1'b1;
      if (probe.ev.credit_full)
        stats_n.credit_full = stats_r.credit_full + 1'b1;

      if (probe.credits < stats_r.min_credit)
        stats_n.min_credit = probe.credits; // new low water mark
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      stats_r <= stats_clear_lp;
    else
      stats_r <= stats_n;
  end

  assign stats_o = stats_r;

  // sampler never counts the clear cycle
  a_clear_run_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(probe.clear && probe.run))
  else
    $error("clear and run high in the same cycle");

  a_stall_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({probe.ev.dmem, probe.ev.rsrv, probe.ev.dx, probe.ev.bt}))
  else
    $error("more than one memory stall class in a cycle");

endmodule

`default_nettype wire

/* src/probe_sampler.sv */
`timescale 1ns/100ps
`default_nettype none

`include "perf_defs.svh"

module probe_sampler import perf_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      freeze_i,
  input  logic                      imem_wait_i,
  input  logic                      dmem_wait_i,
  input  logic                      dmem_en_i,
  input  logic                      rsrv_stall_i,
  input  logic                      dx_stall_i,
  input  logic                      redirect_i,
  input  logic                      instr_retired_i,
  input  logic                      cgni_ready_i,
  input  logic                      cgno_ready_i,
  input  logic                      credit_ready_i,
  input  logic [`PERF_CREDIT_W-1:0] store_credits_i,
  perf_probe_if.sampler             probe
);

  perf_event_s               ev_n;
  perf_event_s               ev_r;
  logic [`PERF_CREDIT_W-1:0] credits_r;
  logic                      freeze_r;
  logic                      freeze_prev_r;

  // memory stalls are exclusive, the rest stand alone
  always_comb
  begin
    ev_n             = '0;
    ev_n.imem        = imem_wait_i;
    ev_n.instr       = instr_retired_i;
    ev_n.cgni_full   = ~cgni_ready_i;
    ev_n.cgno_full   = ~cgno_ready_i;
    ev_n.credit_full = ~credit_ready_i;
    if (dmem_wait_i && dmem_en_i)
      ev_n.dmem = 1'b1;
    else if (rsrv_stall_i)
      ev_n.rsrv = 1'b1;
    else if (dx_stall_i)
      ev_n.dx = 1'b1;
    else if (redirect_i)
      ev_n.bt = 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    ev_r      <= ev_n;
    credits_r <= store_credits_i;
  end

  // both high out of reset so the first unfrozen cycle clears
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      freeze_r      <= 1'b1;
      freeze_prev_r <= 1'b1;
    end
    else
    begin
      freeze_r      <= freeze_i;
      freeze_prev_r <= freeze_r;
    end
  end

  assign probe.clear   = freeze_prev_r & ~freeze_r;
  assign probe.run     = ~freeze_prev_r & ~freeze_r;
  assign probe.ev      = ev_r;
  assign probe.credits = credits_r;

endmodule

`default_nettype wire

/* common/perf_probe_if.sv */
`timescale 1ns/100ps
`default_nettype none

`include "perf_defs.svh"

// classified per-cycle events, sampler to counter bank
interface perf_probe_if import perf_pkg::*; ();

  logic                      run;      // counted cycle
  logic                      clear;    // first cycle out of freeze
  perf_event_s               ev;
  logic [`PERF_CREDIT_W-1:0] credits;

  modport sampler
  (
    output run,
    output clear,
    output ev,
    output credits
  );

  modport bank
  (
    input run,
    input clear,
    input ev,
    input credits
  );

endinterface

`default_nettype wire

/* common/perf_pkg.sv */
`default_nettype none

`include "perf_defs.svh"

package perf_pkg;

  // one cycle worth of classified events
  typedef struct packed {
    logic dmem;         // network write stall
    logic imem;         // bank conflict on instruction fetch
    logic dx;           // bypass or load-use
    logic bt;           // branch taken penalty
    logic rsrv;         // lr.w.acquire wait
    logic cgni_full;
    logic cgno_full;
    logic credit_full;
    logic instr;        // retired instruction
  } perf_event_s;

  typedef struct packed {
    logic [`PERF_CYC_W-1:0]    cycles;
    logic [`PERF_CYC_W-1:0]    instrs;
    logic [`PERF_CNT_W-1:0]    dmem;
    logic [`PERF_CNT_W-1:0]    imem;
    logic [`PERF_CNT_W-1:0]    dx;
    logic [`PERF_CNT_W-1:0]    bt;
    logic [`PERF_CNT_W-1:0]    rsrv;
    logic [`PERF_CNT_W-1:0]    cgni_full;
    logic [`PERF_CNT_W-1:0]    cgno_full;
    logic [`PERF_CNT_W-1:0]    credit_full;
    logic [`PERF_CREDIT_W-1:0] min_credit;
  } perf_stats_s;

  // codes 11..15 are not used and read back as zero
  typedef enum logic [`PERF_SEL_W-1:0] {
    STAT_CYCLES     = 4'd0,
    STAT_INSTRS     = 4'd1,
    STAT_DMEM       = 4'd2,
    STAT_IMEM       = 4'd3,
    STAT_DX         = 4'd4,
    STAT_BT         = 4'd5,
    STAT_RSRV       = 4'd6,
    STAT_CGNI       = 4'd7,
    STAT_CGNO       = 4'd8,
    STAT_CREDIT     = 4'd9,
    STAT_MIN_CREDIT = 4'd10
  } stat_sel_e;

endpackage

`default_nettype wire

/* common/perf_defs.svh */
`ifndef PERF_DEFS_SVH
`define PERF_DEFS_SVH

// stall and full-cycle counters
`define PERF_CNT_W 32

// cycle and instruction counters, also the read data width
`define PERF_CYC_W 40

// remote store credits from the tile
`define PERF_CREDIT_W 6

// statistic selector on the read port
`define PERF_SEL_W 4

`endif
